// ==== list.f ====
hw/wbMemPkg.sv
hw/wbCtrlPkg.sv
hw/memReadIf.sv
hw/asymRamSdp.sv
hw/weightStore.sv
hw/weightStreamer.sv
hw/weightBufferTop.sv
verification/weightBuffer_sva.sv
verification/weightBufferTb.sv

// ==== Makefile ====
TOP = weightBufferTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

# The simulator exits non-zero on $fatal or a failed assertion.
sim:
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== verification/weightBufferTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module weightBufferTb;

  localparam int LaneWidth = wbMemPkg::LaneWidth;
  localparam int LaneCount = wbMemPkg::LaneCount;
  localparam int WordDepth = wbMemPkg::WordDepth;
  localparam int ReadLatency = wbMemPkg::ReadLatency;
  localparam int CreditMax = wbCtrlPkg::CreditMax;
  localparam int LenWidth = wbCtrlPkg::LenWidth;
  localparam int WordWidth = LaneWidth * LaneCount;
  localparam int WordAddrWidth = $clog2(WordDepth);
  localparam int LaneSelWidth = $clog2(LaneCount);
  localparam int LaneAddrWidth = WordAddrWidth + LaneSelWidth;

  localparam int ResetCycles = 8;
  localparam int FillWrites = WordDepth * LaneCount;
  localparam int RewriteCount = 20;
  localparam int SumLen = 8 + 16 + 6 + 12;    // Lengths of the four commands.
  localparam int WithholdCycles = 40;
  localparam int MaxCreditDelay = 3;          // Consumer returns a credit at most this late.
  localparam int TimeoutCycles = ResetCycles + FillWrites + RewriteCount
                                 + SumLen * (ReadLatency + 2) + WithholdCycles
                                 + MaxCreditDelay + 100;

  logic                     clkA = 1'b0;
  logic                     arstN;
  logic                     wrEn;
  logic [LaneAddrWidth-1:0] wrAddr;
  logic [LaneWidth-1:0]     wrData;
  logic                     cmdValid;
  wbCtrlPkg::cmdOpE         cmdOp;
  logic [WordAddrWidth-1:0] cmdBase;
  logic [LenWidth-1:0]      cmdLen;
  logic                     cmdReady;
  logic                     outValid;
  logic [WordWidth-1:0]     outData;
  logic                     outLast;
  logic                     creditReturn;

  logic [LaneWidth-1:0] laneModel [WordDepth][LaneCount];
  logic [WordWidth-1:0] expQ [$];
  bit                   lastQ [$];
  logic [31:0]          lfsrState = 32'h3ad9_858e;
  logic                 busy;            // A command is in flight.
  logic                 withhold;
  int                   owed;            // Credits the consumer still holds.
  int                   creditWait;
  int                   sentCount;
  int                   returnedCount;
  int                   cycleCount = 0;

  weightBufferTop #(
    .LaneWidth   (LaneWidth),
    .LaneCount   (LaneCount),
    .WordDepth   (WordDepth),
    .ReadLatency (ReadLatency),
    .CreditMax   (CreditMax)
  ) i_weightBufferTop (
    .clkA         (clkA),
    .arstN        (arstN),
    .wrEn         (wrEn),
    .wrAddr       (wrAddr),
    .wrData       (wrData),
    .cmdValid     (cmdValid),
    .cmdOp        (cmdOp),
    .cmdBase      (cmdBase),
    .cmdLen       (cmdLen),
    .cmdReady     (cmdReady),
    .outValid     (outValid),
    .outData      (outData),
    .outLast      (outLast),
    .creditReturn (creditReturn)
  );

  always #5 clkA = ~clkA;

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken.
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[30:0], lfsrState[0]};
      lfsrState = lfsrNext(lfsrState);
    end
    return v;
  endfunction

  task automatic failRun(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkEqual(input string sigName, input logic [WordWidth-1:0] got,
                            input logic [WordWidth-1:0] exp);
    assert (got === exp)
      else failRun($sformatf("CHECK FAILED at %0t: %s expected %h, got %h",
                             $time, sigName, exp, got));
  endtask

  function automatic logic [WordWidth-1:0] modelWord(input logic [WordAddrWidth-1:0] a);
    logic [WordWidth-1:0] w;
    for (int l = 0; l < LaneCount; l++) begin
      w[l*LaneWidth +: LaneWidth] = laneModel[a][l];
    end
    return w;
  endfunction

  task automatic queueCommand();
    logic [WordAddrWidth-1:0] a;
    a = cmdBase;
    for (int i = 0; i < int'(cmdLen); i++) begin
      expQ.push_back(modelWord(a));
      lastQ.push_back(i == int'(cmdLen) - 1);
      if (cmdOp == wbCtrlPkg::opStreamUp) begin
        a = a + WordAddrWidth'(1);
      end
    end
  endtask

  task automatic checkOutput();
    logic [WordWidth-1:0] exp;
    bit                   expLast;
    if (outValid) begin
      if (expQ.size() == 0) begin
        failRun($sformatf("outValid at %0t with no word expected", $time));
      end
      exp = expQ.pop_front();
      expLast = lastQ.pop_front();
      checkEqual("outData", outData, exp);
      checkEqual("outLast", WordWidth'(outLast), WordWidth'(expLast));
    end else begin
      checkEqual("outLast", WordWidth'(outLast), '0);
    end
  endtask

  // Consumer side. Holds each credit for a short random time.
  task automatic returnCredits();
    if (outValid) begin
      sentCount++;
      owed++;
    end
    if (creditReturn) begin
      returnedCount++;
    end
    assert (sentCount - returnedCount <= CreditMax)
      else failRun($sformatf("%0d words sent against %0d credits returned, pool of %0d",
                             sentCount, returnedCount, CreditMax));
    if (owed > 0 && !withhold && (creditWait >= MaxCreditDelay || takeBits(1) != '0)) begin
      creditReturn <= 1'b1;
      owed--;
      creditWait = 0;
    end else begin
      creditReturn <= 1'b0;
      if (owed > 0) begin
        creditWait++;
      end
    end
  endtask

  always @(posedge clkA) begin
    if (!arstN) begin
      busy = 1'b0;
      owed = 0;
      creditWait = 0;
      sentCount = 0;
      returnedCount = 0;
      creditReturn <= 1'b0;
    end else begin
      if (wrEn) begin
        laneModel[wrAddr[LaneAddrWidth-1:LaneSelWidth]][wrAddr[LaneSelWidth-1:0]] = wrData;
      end
      checkEqual("cmdReady", WordWidth'(cmdReady), WordWidth'(!busy));
      checkOutput();
      if (outLast) begin
        busy = 1'b0;                  // Ready again on the next cycle.
      end
      if (cmdValid && cmdReady) begin
        queueCommand();
        busy = 1'b1;
      end
      returnCredits();
    end
  end

  always @(posedge clkA) begin
    cycleCount++;
    if (cycleCount > TimeoutCycles) begin
      failRun($sformatf("Run did not finish within %0d cycles", TimeoutCycles));
    end
  end

  task automatic writeLane(input logic [LaneAddrWidth-1:0] a, input logic [LaneWidth-1:0] d);
    wrEn   <= 1'b1;
    wrAddr <= a;
    wrData <= d;
    @(posedge clkA);
  endtask

  task automatic runCommand(input wbCtrlPkg::cmdOpE op, input int base, input int len,
                            input int holdCycles);
    cmdValid <= 1'b1;
    cmdOp    <= op;
    cmdBase  <= WordAddrWidth'(base);
    cmdLen   <= LenWidth'(len);
    if (holdCycles > 0) begin
      withhold <= 1'b1;
    end
    do @(posedge clkA); while (!cmdReady);
    cmdValid <= 1'b0;
    if (holdCycles > 0) begin
      repeat (holdCycles) @(posedge clkA);
      withhold <= 1'b0;             // Credits flow again, stream must resume.
    end
    do @(posedge clkA); while (!outLast);
  endtask

  initial begin
    arstN = 1'b0;
    wrEn = 1'b0;
    wrAddr = '0;
    wrData = '0;
    cmdValid = 1'b0;
    cmdOp = wbCtrlPkg::opStreamUp;
    cmdBase = '0;
    cmdLen = '0;
    creditReturn = 1'b0;
    withhold = 1'b0;
    repeat (ResetCycles) @(posedge clkA);
    arstN <= 1'b1;
    @(posedge clkA);
    checkEqual("outValid", WordWidth'(outValid), '0);
    checkEqual("outLast", WordWidth'(outLast), '0);
    checkEqual("cmdReady", WordWidth'(cmdReady), WordWidth'(1));

    for (int a = 0; a < FillWrites; a++) begin
      writeLane(LaneAddrWidth'(a), LaneWidth'(takeBits(LaneWidth)));
    end
    // Rewrite random lanes of words 0 to 7.
    for (int i = 0; i < RewriteCount; i++) begin
      writeLane(LaneAddrWidth'(takeBits(LaneSelWidth + 3)), LaneWidth'(takeBits(LaneWidth)));
    end
    wrEn <= 1'b0;
    @(posedge clkA);

    runCommand(wbCtrlPkg::opStreamUp, 0, 8, 0);
    runCommand(wbCtrlPkg::opStreamUp, 20, 16, 0);
    runCommand(wbCtrlPkg::opRepeat, 37, 6, 0);
    runCommand(wbCtrlPkg::opStreamUp, 40, 12, WithholdCycles);

    repeat (2) @(posedge clkA);
    if (expQ.size() == 0 && !busy) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      failRun("Expected words still pending at the end of the run");
    end
  end

endmodule

`default_nettype wire

// ==== verification/weightBuffer_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module weightBuffer_sva #(
  parameter int CreditMax = wbCtrlPkg::CreditMax,
  parameter int CreditWidth = $clog2(CreditMax + 1)
) (
  input logic                   clkA,
  input logic                   arstN,
  input logic [CreditWidth-1:0] creditCount,
  input logic                   rdEn,
  input logic                   creditReturn,
  input logic                   cmdReady,
  input logic                   outValid,
  input logic                   outLast
);

  int poolLeft;                     // Credits left by count of issues and returns.

  always_ff @(posedge clkA or negedge arstN) begin
    if (!arstN) begin
      poolLeft <= CreditMax;
    end else begin
      poolLeft <= poolLeft - int'(rdEn) + int'(creditReturn);
    end
  end

  // Returns never push the pool past its size.
  creditBound: assert property (@(posedge clkA) disable iff (!arstN)
    creditCount <= CreditWidth'(CreditMax))
    else $error("credit count above the pool size");

  // Every issued read must already be paid for.
  noIssueWithoutCredit: assert property (@(posedge clkA) disable iff (!arstN)
    rdEn |-> (poolLeft > 0))
    else $error("read issued with no credit left");

  // The last word frames a valid output and frees the streamer.
  lastEndsCommand: assert property (@(posedge clkA) disable iff (!arstN)
    outLast |=> ($past(outValid) && cmdReady))
    else $error("outLast without outValid or not followed by cmdReady");

endmodule

bind weightStreamer weightBuffer_sva #(
  .CreditMax   (CreditMax),
  .CreditWidth (CreditWidth)
) i_weightBufferSva (
  .clkA         (clkA),
  .arstN        (arstN),
  .creditCount  (creditCount),
  .rdEn         (issue),
  .creditReturn (creditReturn),
  .cmdReady     (cmdReady),
  .outValid     (outValid),
  .outLast      (outLast)
);

`default_nettype wire

// ==== hw/weightBufferTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module weightBufferTop #(
  parameter  int LaneWidth = wbMemPkg::LaneWidth,
  parameter  int LaneCount = wbMemPkg::LaneCount,
  parameter  int WordDepth = wbMemPkg::WordDepth,
  parameter  int ReadLatency = wbMemPkg::ReadLatency,
  parameter  int CreditMax = wbCtrlPkg::CreditMax,
  localparam int WordAddrWidth = $clog2(WordDepth),
  localparam int LaneAddrWidth = WordAddrWidth + $clog2(LaneCount),
  localparam int WordWidth = LaneWidth * LaneCount
) (
  input  logic                           clkA,
  input  logic                           arstN,
  input  logic                           wrEn,
  input  logic [LaneAddrWidth-1:0]       wrAddr,
  input  logic [LaneWidth-1:0]           wrData,
  input  logic                           cmdValid,
  input  wbCtrlPkg::cmdOpE               cmdOp,
  input  logic [WordAddrWidth-1:0]       cmdBase,
  input  logic [wbCtrlPkg::LenWidth-1:0] cmdLen,
  output logic                           cmdReady,
  output logic                           outValid,
  output logic [WordWidth-1:0]           outData,
  output logic                           outLast,
  input  logic                           creditReturn
);

  memReadIf #(
    .AddrWidth (WordAddrWidth),
    .DataWidth (WordWidth)
  ) i_memReadIf ();

  weightStore #(
    .LaneWidth   (LaneWidth),
    .LaneCount   (LaneCount),
    .WordDepth   (WordDepth),
    .ReadLatency (ReadLatency)
  ) i_weightStore (
    .clkA   (clkA),
    .arstN  (arstN),
    .wrEn   (wrEn),
    .wrAddr (wrAddr),
    .wrData (wrData),
    .rd     (i_memReadIf.responder)
  );

  weightStreamer #(
    .LaneWidth   (LaneWidth),
    .LaneCount   (LaneCount),
    .WordDepth   (WordDepth),
    .ReadLatency (ReadLatency),
    .CreditMax   (CreditMax)
  ) i_weightStreamer (
    .clkA         (clkA),
    .arstN        (arstN),
    .cmdValid     (cmdValid),
    .cmdOp        (cmdOp),
    .cmdBase      (cmdBase),
    .cmdLen       (cmdLen),
    .cmdReady     (cmdReady),
    .rd           (i_memReadIf.requester),
    .outValid     (outValid),
    .outData      (outData),
    .outLast      (outLast),
    .creditReturn (creditReturn)
  );

endmodule

`default_nettype wire

// ==== hw/weightStreamer.sv ====
`timescale 1ns/1ps
`default_nettype none

module weightStreamer #(
  parameter  int LaneWidth = wbMemPkg::LaneWidth,
  parameter  int LaneCount = wbMemPkg::LaneCount,
  parameter  int WordDepth = wbMemPkg::WordDepth,
  parameter  int ReadLatency = wbMemPkg::ReadLatency,
  parameter  int CreditMax = wbCtrlPkg::CreditMax,
  localparam int WordAddrWidth = $clog2(WordDepth),
  localparam int WordWidth = LaneWidth * LaneCount,
  localparam int LenWidth = wbCtrlPkg::LenWidth,
  localparam int CreditWidth = $clog2(CreditMax + 1)
) (
  input  logic                     clkA,
  input  logic                     arstN,
  input  logic                     cmdValid,
  input  wbCtrlPkg::cmdOpE         cmdOp,
  input  logic [WordAddrWidth-1:0] cmdBase,
  input  logic [LenWidth-1:0]      cmdLen,
  output logic                     cmdReady,
  memReadIf.requester              rd,
  output logic                     outValid,
  output logic [WordWidth-1:0]     outData,
  output logic                     outLast,
  input  logic                     creditReturn
);

  wbCtrlPkg::streamStateE   state;
  wbCtrlPkg::cmdOpE         curOp;
  logic [WordAddrWidth-1:0] curAddr;
  logic [LenWidth-1:0]      issueLeft;     // Reads still to issue.
  logic [LenWidth-1:0]      retLeft;       // Words still to come back.
  logic [CreditWidth-1:0]   creditCount;
  logic                     cmdAccept;
  logic                     issue;

  if (ReadLatency < 1) begin : gLatencyCheck
    $error("weightStreamer needs a read latency of at least 1");
  end

  assign cmdReady  = (state == wbCtrlPkg::stIdle);
  assign cmdAccept = cmdValid && cmdReady;
  assign issue     = (state == wbCtrlPkg::stIssue) && (creditCount != '0);

  assign rd.rdEn   = issue;
  assign rd.rdAddr = curAddr;

  always_ff @(posedge clkA or negedge arstN) begin
    if (!arstN) begin
      state     <= wbCtrlPkg::stIdle;
      curOp     <= wbCtrlPkg::opStreamUp;
      curAddr   <= '0;
      issueLeft <= '0;
    end else begin
      case (state)
        wbCtrlPkg::stIdle: begin
          if (cmdAccept) begin
            curOp     <= cmdOp;
            curAddr   <= cmdBase;
            issueLeft <= cmdLen;
            state     <= wbCtrlPkg::stIssue;
          end
        end
        wbCtrlPkg::stIssue: begin
          if (issue) begin
            issueLeft <= issueLeft - LenWidth'(1);
            if (curOp == wbCtrlPkg::opStreamUp) begin
              curAddr <= curAddr + WordAddrWidth'(1);   // Repeat keeps the address.
            end
            if (issueLeft == LenWidth'(1)) begin
              state <= wbCtrlPkg::stDrain;
            end
          end
        end
        wbCtrlPkg::stDrain: begin
          if (outLast) begin
            state <= wbCtrlPkg::stIdle;   // Ready again one cycle after the last word.
          end
        end
        default: state <= wbCtrlPkg::stIdle;
      endcase
    end
  end

  // Spend on issue, refill on return; both may land together.
  always_ff @(posedge clkA or negedge arstN) begin
    if (!arstN) begin
      creditCount <= CreditWidth'(CreditMax);
    end else begin
      case ({issue, creditReturn})
        2'b10:   creditCount <= creditCount - CreditWidth'(1);
        2'b01:   creditCount <= creditCount + CreditWidth'(1);
        default: creditCount <= creditCount;
      endcase
    end
  end

  always_ff @(posedge clkA or negedge arstN) begin
    if (!arstN) begin
      retLeft <= '0;
    end else if (cmdAccept) begin
      retLeft <= cmdLen;
    end else if (rd.rdValid) begin
      retLeft <= retLeft - LenWidth'(1);
    end
  end

  always_ff @(posedge clkA or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
      outLast  <= 1'b0;
    end else begin
      outValid <= rd.rdValid;
      outLast  <= rd.rdValid && (retLeft == LenWidth'(1));
    end
  end

  always_ff @(posedge clkA) begin
    if (rd.rdValid) begin
      outData <= rd.rdData;
    end
  end

endmodule

`default_nettype wire

// ==== hw/weightStore.sv ====
`timescale 1ns/1ps
`default_nettype none

module weightStore #(
  parameter  int LaneWidth = wbMemPkg::LaneWidth,
  parameter  int LaneCount = wbMemPkg::LaneCount,
  parameter  int WordDepth = wbMemPkg::WordDepth,
  parameter  int ReadLatency = wbMemPkg::ReadLatency,
  localparam int LaneAddrWidth = $clog2(WordDepth) + $clog2(LaneCount),
  localparam int WordWidth = LaneWidth * LaneCount
) (
  input  logic                     clkA,
  input  logic                     arstN,
  input  logic                     wrEn,
  input  logic [LaneAddrWidth-1:0] wrAddr,
  input  logic [LaneWidth-1:0]     wrData,
  memReadIf.responder              rd
);

  logic [WordWidth-1:0]   ramData;
  logic [ReadLatency-1:0] validPipe;   // Stage 0 matches the RAM register.

  asymRamSdp #(
    .LaneWidth (LaneWidth),
    .LaneCount (LaneCount),
    .WordDepth (WordDepth)
  ) i_asymRamSdp (
    .clkA   (clkA),
    .wrEn   (wrEn),
    .wrAddr (wrAddr),
    .wrData (wrData),
    .rdEn   (rd.rdEn),
    .rdAddr (rd.rdAddr),
    .rdData (ramData)
  );

  always_ff @(posedge clkA or negedge arstN) begin
    if (!arstN) begin
      validPipe <= '0;
    end else begin
      validPipe[0] <= rd.rdEn;
      for (int i = 1; i < ReadLatency; i++) begin
        validPipe[i] <= validPipe[i-1];
      end
    end
  end

  if (ReadLatency > 1) begin : gDataPipe
    logic [WordWidth-1:0] dataPipe [ReadLatency-1];

    // Free-running shift; the valid bit marks the live words.
    always_ff @(posedge clkA) begin
      dataPipe[0] <= ramData;
      for (int i = 1; i < ReadLatency - 1; i++) begin
        dataPipe[i] <= dataPipe[i-1];
      end
    end

    assign rd.rdData = dataPipe[ReadLatency-2];
  end else begin : gNoPipe
    assign rd.rdData = ramData;
  end

  assign rd.rdValid = validPipe[ReadLatency-1];

endmodule

`default_nettype wire

// ==== hw/asymRamSdp.sv ====
`timescale 1ns/1ps
`default_nettype none

module asymRamSdp #(
  parameter  int LaneWidth = wbMemPkg::LaneWidth,
  parameter  int LaneCount = wbMemPkg::LaneCount,
  parameter  int WordDepth = wbMemPkg::WordDepth,
  localparam int LaneSelWidth = $clog2(LaneCount),
  localparam int WordAddrWidth = $clog2(WordDepth),
  localparam int LaneAddrWidth = WordAddrWidth + LaneSelWidth,
  localparam int WordWidth = LaneWidth * LaneCount
) (
  input  logic                     clkA,
  input  logic                     wrEn,
  input  logic [LaneAddrWidth-1:0] wrAddr,   // Lane address.
  input  logic [LaneWidth-1:0]     wrData,
  input  logic                     rdEn,
  input  logic [WordAddrWidth-1:0] rdAddr,   // Word address.
  output logic [WordWidth-1:0]     rdData
);

  logic [WordWidth-1:0]     mem [WordDepth];
  logic [WordAddrWidth-1:0] wrWord;
  logic [LaneSelWidth-1:0]  wrLane;
  logic [LaneCount-1:0]     laneWe;

  assign wrWord = wrAddr[LaneAddrWidth-1:LaneSelWidth];
  assign wrLane = wrAddr[LaneSelWidth-1:0];

  // One-hot lane enable from the low address bits.
  always_comb begin
    laneWe = '0;
    laneWe[wrLane] = wrEn;
  end

  // Only the selected lane changes; neighbours keep their contents.
  always_ff @(posedge clkA) begin
    for (int l = 0; l < LaneCount; l++) begin
      if (laneWe[l]) begin
        mem[wrWord][l*LaneWidth +: LaneWidth] <= wrData;
      end
    end
  end

  // Wide read port, read-before-write on an address collision.
  always_ff @(posedge clkA) begin
    if (rdEn) begin
      rdData <= mem[rdAddr];
    end
  end

endmodule

`default_nettype wire

// ==== hw/memReadIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface memReadIf #(
  parameter int AddrWidth = 6,
  parameter int DataWidth = 32
);

  logic                 rdEn;
  logic [AddrWidth-1:0] rdAddr;
  logic [DataWidth-1:0] rdData;
  logic                 rdValid;

  // Streamer side.
  modport requester (
    output rdEn, rdAddr,
    input  rdData, rdValid
  );

  // Store side, one rdValid per rdEn in issue order.
  modport responder (
    input  rdEn, rdAddr,
    output rdData, rdValid
  );

endinterface

`default_nettype wire

// ==== hw/wbCtrlPkg.sv ====
`default_nettype none

package wbCtrlPkg;

  typedef enum logic {
    opStreamUp = 1'b0,               // Consecutive words from the base.
    opRepeat   = 1'b1                // Same word cmdLen times.
  } cmdOpE;

  typedef enum logic [1:0] {
    stIdle  = 2'd0,
    stIssue = 2'd1,
    stDrain = 2'd2
  } streamStateE;

  localparam int CreditMax = 4;      // Credit pool toward the array.
  localparam int LenWidth = 8;       // Width of the command length field.

endpackage

`default_nettype wire

// ==== hw/wbMemPkg.sv ====
`default_nettype none

package wbMemPkg;

  // Memory geometry defaults.
  localparam int LaneWidth = 8;      // Bits per host write.
  localparam int LaneCount = 4;      // Lanes packed into one wide word.
  localparam int WordDepth = 64;     // Wide words in the RAM.
  localparam int ReadLatency = 3;    // Read request to data, at least 1.

  // Widths derived from the defaults above.
  localparam int WordWidth = LaneWidth * LaneCount;
  localparam int WordAddrWidth = $clog2(WordDepth);
  localparam int LaneSelWidth = $clog2(LaneCount);
  localparam int LaneAddrWidth = WordAddrWidth + LaneSelWidth;

  // Lane address layout: word index in the high bits, lane in the low bits.
  localparam int LaneSelLsb = 0;
  localparam int WordSelLsb = LaneSelWidth;

endpackage

`default_nettype wire
